// File: rtl/hk_pkg.sv
// ####################################################################
// Shared widths, register map and field positions of the housekeeping
// block. Offsets are byte offsets and are decoded on word boundaries.
// ####################################################################
`default_nettype none

package hk_pkg;

  localparam int ADDR_W = 8;
  localparam int DATA_W = 32;
  localparam int GPIO_W = 16;
  localparam int IRQ_W  = 4;

  typedef logic [ADDR_W-1:0]   addr_t;
  typedef logic [DATA_W-1:0]   data_t;
  typedef logic [DATA_W/8-1:0] strb_t;
  typedef logic [GPIO_W-1:0]   gpio_t;
  typedef logic [1:0]          sel_t;
  typedef logic [IRQ_W-1:0]    irq_t;

  // register map
  localparam addr_t OFS_GPIO_DATA = 8'h00;
  localparam addr_t OFS_GPIO_OEB  = 8'h04;
  localparam addr_t OFS_GPIO_PU   = 8'h08;
  localparam addr_t OFS_GPIO_PD   = 8'h0C;
  localparam addr_t OFS_TRAP_DEST = 8'h3C;
  localparam addr_t OFS_IRQA_SRC  = 8'h40;
  localparam addr_t OFS_IRQB_SRC  = 8'h44;
  localparam addr_t OFS_TIM0_CFG  = 8'h5C;
  localparam addr_t OFS_TIM0_VAL  = 8'h60;
  localparam addr_t OFS_TIM0_DAT  = 8'h64;
  localparam addr_t OFS_TIM1_CFG  = 8'h68;
  localparam addr_t OFS_TIM1_VAL  = 8'h6C;
  localparam addr_t OFS_TIM1_DAT  = 8'h70;

  // timer config bits
  localparam int CFG_EN      = 0;
  localparam int CFG_CONT    = 1;
  localparam int CFG_IRQ_EN  = 2;
  localparam int CFG_EXPIRED = 3;

  typedef logic [CFG_EXPIRED:0] tim_cfg_t;

  // code n picks pin or input base + n (trap) or base + n - 1 (irq)
  localparam int TRAP_PIN_BASE = 10;
  localparam int IRQA_IN_BASE  = 0;
  localparam int IRQB_IN_BASE  = 3;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WRESP,
    ST_RRESP
  } axil_state_t;

endpackage

`default_nettype wire

// File: rtl/axil_slave_fsm.sv
// ####################################################################
// AXI4-Lite slave, one transaction at a time, writes win over reads.
// AW and W must be valid together; responses are always OKAY.
// ####################################################################
`default_nettype none

module axil_slave_fsm (
  input  logic           clk_i,
  input  logic           rst_n_i,
  // write address and data
  input  logic           s_awvalid_i,
  output logic           s_awready_o,
  input  hk_pkg::addr_t  s_awaddr_i,
  input  logic           s_wvalid_i,
  output logic           s_wready_o,
  input  hk_pkg::data_t  s_wdata_i,
  input  hk_pkg::strb_t  s_wstrb_i,
  // write response
  output logic           s_bvalid_o,
  input  logic           s_bready_i,
  // read address and data
  input  logic           s_arvalid_i,
  output logic           s_arready_o,
  input  hk_pkg::addr_t  s_araddr_i,
  output logic           s_rvalid_o,
  input  logic           s_rready_i,
  output hk_pkg::data_t  s_rdata_o,
  // register side
  output hk_pkg::addr_t  reg_addr_o,
  output hk_pkg::data_t  reg_wdata_o,
  output hk_pkg::strb_t  reg_wstrb_o,
  output logic           reg_wr_o,
  output logic           reg_rd_o,
  input  hk_pkg::data_t  reg_rdata_i
);
  import hk_pkg::*;

  axil_state_t state_q;
  axil_state_t state_d;
  data_t       rdata_q;
  logic        wr_accept;
  logic        rd_accept;
  logic        wr_pending;

  // a half-presented write still blocks the read
  assign wr_pending = s_awvalid_i | s_wvalid_i;
  assign wr_accept  = (state_q == ST_IDLE) && s_awvalid_i && s_wvalid_i;
  assign rd_accept  = (state_q == ST_IDLE) && s_arvalid_i && !wr_pending;

  assign s_awready_o = wr_accept;
  assign s_wready_o  = wr_accept;
  assign s_arready_o = rd_accept;

  assign reg_addr_o  = wr_accept ? s_awaddr_i : s_araddr_i;
  assign reg_wdata_o = s_wdata_i;
  assign reg_wstrb_o = s_wstrb_i;
  assign reg_wr_o    = wr_accept;
  assign reg_rd_o    = rd_accept;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (wr_accept) begin
          state_d = ST_WRESP;
        end else if (rd_accept) begin
          state_d = ST_RRESP;
        end
      end
      ST_WRESP: begin
        if (s_bready_i) begin
          state_d = ST_IDLE;
        end
      end
      ST_RRESP: begin
        if (s_rready_i) begin
          state_d = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // read data held until rready
  always_ff @(posedge clk_i) begin
    if (rd_accept) begin
      rdata_q <= reg_rdata_i;
    end
  end

  assign s_bvalid_o = (state_q == ST_WRESP);
  assign s_rvalid_o = (state_q == ST_RRESP);
  assign s_rdata_o  = rdata_q;

endmodule

`default_nettype wire

// File: rtl/hk_regs.sv
// ####################################################################
// GPIO, trap routing and irq select registers plus the timer decode.
// Address bits 1:0 are ignored; unmapped reads return 0.
// A nonzero trap code takes over pins 11 to 13.
// ####################################################################
`default_nettype none

module hk_regs (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  hk_pkg::addr_t     reg_addr_i,
  input  hk_pkg::data_t     reg_wdata_i,
  input  hk_pkg::strb_t     reg_wstrb_i,
  input  logic              reg_wr_i,
  input  logic              reg_rd_i,
  output hk_pkg::data_t     reg_rdata_o,
  input  hk_pkg::gpio_t     gpio_in_i,
  output hk_pkg::gpio_t     gpio_out_o,
  output hk_pkg::gpio_t     gpio_outenb_o,
  output hk_pkg::gpio_t     gpio_pullupb_o,
  output hk_pkg::gpio_t     gpio_pulldownb_o,
  input  logic              trap_i,
  output logic [1:0]        irq_sel_o,
  output logic              tim0_cfg_we_o,
  output logic              tim1_cfg_we_o,
  output hk_pkg::strb_t     tim0_val_we_o,
  output hk_pkg::strb_t     tim1_val_we_o,
  output hk_pkg::strb_t     tim0_dat_we_o,
  output hk_pkg::strb_t     tim1_dat_we_o,
  output hk_pkg::data_t     tim_wdata_o,
  input  hk_pkg::tim_cfg_t  tim0_cfg_i,
  input  hk_pkg::tim_cfg_t  tim1_cfg_i,
  input  hk_pkg::data_t     tim0_val_i,
  input  hk_pkg::data_t     tim0_dat_i,
  input  hk_pkg::data_t     tim1_val_i,
  input  hk_pkg::data_t     tim1_dat_i
);
  import hk_pkg::*;

  gpio_t gpio_q;
  gpio_t oeb_q;
  gpio_t pu_q;
  gpio_t pd_q;
  sel_t  trap_dest_q;
  sel_t  irqa_src_q;
  sel_t  irqb_src_q;
  addr_t word_ofs;
  data_t rd_data;

  // byte-wise update of a 16 bit pin register
  function automatic gpio_t wr_pins(input gpio_t cur, input data_t wd, input strb_t st);
    gpio_t res;
    res = cur;
    if (st[0]) res[7:0] = wd[7:0];
    if (st[1]) res[15:8] = wd[15:8];
    return res;
  endfunction

  function automatic logic pick_src(input sel_t sel, input gpio_t pins, input int base);
    return (sel == '0) ? 1'b0 : pins[base + int'(sel) - 1];
  endfunction

  assign word_ofs = {reg_addr_i[ADDR_W-1:2], 2'b00};

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      gpio_q      <= '0;
      oeb_q       <= '1;
      pu_q        <= '0;
      pd_q        <= '0;
      trap_dest_q <= '0;
      irqa_src_q  <= '0;
      irqb_src_q  <= '0;
    end else if (reg_wr_i) begin
      case (word_ofs)
        OFS_GPIO_DATA: gpio_q <= wr_pins(gpio_q, reg_wdata_i, reg_wstrb_i);
        OFS_GPIO_OEB:  oeb_q  <= wr_pins(oeb_q, reg_wdata_i, reg_wstrb_i);
        OFS_GPIO_PU:   pu_q   <= wr_pins(pu_q, reg_wdata_i, reg_wstrb_i);
        OFS_GPIO_PD:   pd_q   <= wr_pins(pd_q, reg_wdata_i, reg_wstrb_i);
        OFS_TRAP_DEST: if (reg_wstrb_i[0]) trap_dest_q <= reg_wdata_i[1:0];
        OFS_IRQA_SRC:  if (reg_wstrb_i[0]) irqa_src_q <= reg_wdata_i[1:0];
        OFS_IRQB_SRC:  if (reg_wstrb_i[0]) irqb_src_q <= reg_wdata_i[1:0];
        default: ;
      endcase
    end
  end

  // trap override of the pin controls
  always_comb begin
    gpio_out_o       = gpio_q;
    gpio_outenb_o    = oeb_q;
    gpio_pullupb_o   = pu_q;
    gpio_pulldownb_o = pd_q;
    if (trap_dest_q != '0) begin
      for (int n = 1; n <= 3; n++) begin
        gpio_outenb_o[TRAP_PIN_BASE + n]    = 1'b0;
        gpio_pullupb_o[TRAP_PIN_BASE + n]   = 1'b1;
        gpio_pulldownb_o[TRAP_PIN_BASE + n] = 1'b1;
      end
      gpio_out_o[TRAP_PIN_BASE + int'(trap_dest_q)] = trap_i;
    end
  end

  assign irq_sel_o[0] = pick_src(irqa_src_q, gpio_in_i, IRQA_IN_BASE);
  assign irq_sel_o[1] = pick_src(irqb_src_q, gpio_in_i, IRQB_IN_BASE);

  // timer write enables
  assign tim0_cfg_we_o = reg_wr_i && (word_ofs == OFS_TIM0_CFG) && reg_wstrb_i[0];
  assign tim1_cfg_we_o = reg_wr_i && (word_ofs == OFS_TIM1_CFG) && reg_wstrb_i[0];
  assign tim0_val_we_o = (reg_wr_i && (word_ofs == OFS_TIM0_VAL)) ? reg_wstrb_i : '0;
  assign tim1_val_we_o = (reg_wr_i && (word_ofs == OFS_TIM1_VAL)) ? reg_wstrb_i : '0;
  assign tim0_dat_we_o = (reg_wr_i && (word_ofs == OFS_TIM0_DAT)) ? reg_wstrb_i : '0;
  assign tim1_dat_we_o = (reg_wr_i && (word_ofs == OFS_TIM1_DAT)) ? reg_wstrb_i : '0;
  assign tim_wdata_o   = reg_wdata_i;

  always_comb begin
    rd_data = '0;
    if (reg_rd_i) begin
      case (word_ofs)
        OFS_GPIO_DATA: rd_data = {gpio_out_o, gpio_in_i};
        OFS_GPIO_OEB:  rd_data = {{(DATA_W-GPIO_W){1'b0}}, oeb_q};
        OFS_GPIO_PU:   rd_data = {{(DATA_W-GPIO_W){1'b0}}, pu_q};
        OFS_GPIO_PD:   rd_data = {{(DATA_W-GPIO_W){1'b0}}, pd_q};
        OFS_TRAP_DEST: rd_data = {{(DATA_W-2){1'b0}}, trap_dest_q};
        OFS_IRQA_SRC:  rd_data = {{(DATA_W-2){1'b0}}, irqa_src_q};
        OFS_IRQB_SRC:  rd_data = {{(DATA_W-2){1'b0}}, irqb_src_q};
        OFS_TIM0_CFG:  rd_data = {{(DATA_W-CFG_EXPIRED-1){1'b0}}, tim0_cfg_i};
        OFS_TIM0_VAL:  rd_data = tim0_val_i;
        OFS_TIM0_DAT:  rd_data = tim0_dat_i;
        OFS_TIM1_CFG:  rd_data = {{(DATA_W-CFG_EXPIRED-1){1'b0}}, tim1_cfg_i};
        OFS_TIM1_VAL:  rd_data = tim1_val_i;
        OFS_TIM1_DAT:  rd_data = tim1_dat_i;
        default:       rd_data = '0;
      endcase
    end
  end

  assign reg_rdata_o = rd_data;

endmodule

`default_nettype wire

// File: rtl/hk_timer.sv
// ####################################################################
// Count-down timer. Counts while enabled, expires at zero, then
// reloads (continuous) or stops (one-shot). Expiry is sticky until
// the next config write. A value write takes priority over counting.
// ####################################################################
`default_nettype none

module hk_timer (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              cfg_we_i,
  input  hk_pkg::strb_t     val_we_i,
  input  hk_pkg::strb_t     dat_we_i,
  input  hk_pkg::data_t     wdata_i,
  output hk_pkg::tim_cfg_t  cfg_o,
  output hk_pkg::data_t     val_o,
  output hk_pkg::data_t     dat_o,
  output logic              irq_o
);
  import hk_pkg::*;

  tim_cfg_t cfg_q;
  data_t    val_q;
  data_t    dat_q;
  logic     count;
  logic     expire;

  assign count  = cfg_q[CFG_EN] && !(|val_we_i);
  assign expire = count && (val_q == '0);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cfg_q <= '0;
    end else if (cfg_we_i) begin
      cfg_q[CFG_EN]      <= wdata_i[CFG_EN];
      cfg_q[CFG_CONT]    <= wdata_i[CFG_CONT];
      cfg_q[CFG_IRQ_EN]  <= wdata_i[CFG_IRQ_EN];
      cfg_q[CFG_EXPIRED] <= 1'b0;
    end else if (expire) begin
      cfg_q[CFG_EXPIRED] <= 1'b1;
      if (!cfg_q[CFG_CONT]) begin
        cfg_q[CFG_EN] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      val_q <= '0;
      dat_q <= '0;
    end else begin
      for (int b = 0; b < DATA_W/8; b++) begin
        if (val_we_i[b]) val_q[8*b +: 8] <= wdata_i[8*b +: 8];
        if (dat_we_i[b]) dat_q[8*b +: 8] <= wdata_i[8*b +: 8];
      end
      if (count) begin
        if (val_q != '0) begin
          val_q <= val_q - 1'b1;
        end else if (cfg_q[CFG_CONT]) begin
          // reload sees the old dat if both change together
          val_q <= dat_q;
        end
      end
    end
  end

  assign cfg_o = cfg_q;
  assign val_o = val_q;
  assign dat_o = dat_q;
  assign irq_o = cfg_q[CFG_EXPIRED] & cfg_q[CFG_IRQ_EN];

endmodule

`default_nettype wire

// File: rtl/hk_top.sv
// ####################################################################
// Housekeeping block top: AXI4-Lite slave, register block, two timers.
// irq_o bit 0/1 are the timers, bit 2/3 the GPIO input selects.
// ####################################################################
`default_nettype none

module hk_top (
  input  logic           clk_i,
  input  logic           rst_n_i,
  input  logic           s_awvalid_i,
  output logic           s_awready_o,
  input  hk_pkg::addr_t  s_awaddr_i,
  input  logic           s_wvalid_i,
  output logic           s_wready_o,
  input  hk_pkg::data_t  s_wdata_i,
  input  hk_pkg::strb_t  s_wstrb_i,
  output logic           s_bvalid_o,
  input  logic           s_bready_i,
  input  logic           s_arvalid_i,
  output logic           s_arready_o,
  input  hk_pkg::addr_t  s_araddr_i,
  output logic           s_rvalid_o,
  input  logic           s_rready_i,
  output hk_pkg::data_t  s_rdata_o,
  input  hk_pkg::gpio_t  gpio_in_i,
  output hk_pkg::gpio_t  gpio_out_o,
  output hk_pkg::gpio_t  gpio_outenb_o,
  output hk_pkg::gpio_t  gpio_pullupb_o,
  output hk_pkg::gpio_t  gpio_pulldownb_o,
  input  logic           trap_i,
  output hk_pkg::irq_t   irq_o
);
  import hk_pkg::*;

  addr_t    reg_addr;
  data_t    reg_wdata;
  strb_t    reg_wstrb;
  logic     reg_wr;
  logic     reg_rd;
  data_t    reg_rdata;
  logic     [1:0] irq_sel;
  logic     tim0_cfg_we;
  logic     tim1_cfg_we;
  strb_t    tim0_val_we;
  strb_t    tim1_val_we;
  strb_t    tim0_dat_we;
  strb_t    tim1_dat_we;
  data_t    tim_wdata;
  tim_cfg_t tim0_cfg;
  tim_cfg_t tim1_cfg;
  data_t    tim0_val;
  data_t    tim1_val;
  data_t    tim0_dat;
  data_t    tim1_dat;
  logic     tim0_irq;
  logic     tim1_irq;

  axil_slave_fsm u_axil (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .s_awvalid_i (s_awvalid_i),
    .s_awready_o (s_awready_o),
    .s_awaddr_i  (s_awaddr_i),
    .s_wvalid_i  (s_wvalid_i),
    .s_wready_o  (s_wready_o),
    .s_wdata_i   (s_wdata_i),
    .s_wstrb_i   (s_wstrb_i),
    .s_bvalid_o  (s_bvalid_o),
    .s_bready_i  (s_bready_i),
    .s_arvalid_i (s_arvalid_i),
    .s_arready_o (s_arready_o),
    .s_araddr_i  (s_araddr_i),
    .s_rvalid_o  (s_rvalid_o),
    .s_rready_i  (s_rready_i),
    .s_rdata_o   (s_rdata_o),
    .reg_addr_o  (reg_addr),
    .reg_wdata_o (reg_wdata),
    .reg_wstrb_o (reg_wstrb),
    .reg_wr_o    (reg_wr),
    .reg_rd_o    (reg_rd),
    .reg_rdata_i (reg_rdata)
  );

  hk_regs u_regs (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .reg_addr_i       (reg_addr),
    .reg_wdata_i      (reg_wdata),
    .reg_wstrb_i      (reg_wstrb),
    .reg_wr_i         (reg_wr),
    .reg_rd_i         (reg_rd),
    .reg_rdata_o      (reg_rdata),
    .gpio_in_i        (gpio_in_i),
    .gpio_out_o       (gpio_out_o),
    .gpio_outenb_o    (gpio_outenb_o),
    .gpio_pullupb_o   (gpio_pullupb_o),
    .gpio_pulldownb_o (gpio_pulldownb_o),
    .trap_i           (trap_i),
    .irq_sel_o        (irq_sel),
    .tim0_cfg_we_o    (tim0_cfg_we),
    .tim1_cfg_we_o    (tim1_cfg_we),
    .tim0_val_we_o    (tim0_val_we),
    .tim1_val_we_o    (tim1_val_we),
    .tim0_dat_we_o    (tim0_dat_we),
    .tim1_dat_we_o    (tim1_dat_we),
    .tim_wdata_o      (tim_wdata),
    .tim0_cfg_i       (tim0_cfg),
    .tim1_cfg_i       (tim1_cfg),
    .tim0_val_i       (tim0_val),
    .tim0_dat_i       (tim0_dat),
    .tim1_val_i       (tim1_val),
    .tim1_dat_i       (tim1_dat)
  );

  hk_timer u_tim0 (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .cfg_we_i (tim0_cfg_we),
    .val_we_i (tim0_val_we),
    .dat_we_i (tim0_dat_we),
    .wdata_i  (tim_wdata),
    .cfg_o    (tim0_cfg),
    .val_o    (tim0_val),
    .dat_o    (tim0_dat),
    .irq_o    (tim0_irq)
  );

  hk_timer u_tim1 (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .cfg_we_i (tim1_cfg_we),
    .val_we_i (tim1_val_we),
    .dat_we_i (tim1_dat_we),
    .wdata_i  (tim_wdata),
    .cfg_o    (tim1_cfg),
    .val_o    (tim1_val),
    .dat_o    (tim1_dat),
    .irq_o    (tim1_irq)
  );

  assign irq_o = {irq_sel[1], irq_sel[0], tim1_irq, tim0_irq};

endmodule

`default_nettype wire

// File: verification/tb_hk_top.sv
// ####################################################################
// Testbench for hk_top. Inputs change on the rising edge, outputs are
// sampled on the falling edge. A shadow model holds the GPIO and
// select registers; timer behavior is checked against fixed values.
// ####################################################################
`default_nettype none

module tb_hk_top;
  import hk_pkg::*;

  localparam int CYCLE_LIMIT = 20000;

  logic  clk_i = 1'b0;
  logic  rst_n_i;
  logic  s_awvalid_i;
  logic  s_awready_o;
  addr_t s_awaddr_i;
  logic  s_wvalid_i;
  logic  s_wready_o;
  data_t s_wdata_i;
  strb_t s_wstrb_i;
  logic  s_bvalid_o;
  logic  s_bready_i;
  logic  s_arvalid_i;
  logic  s_arready_o;
  addr_t s_araddr_i;
  logic  s_rvalid_o;
  logic  s_rready_i;
  data_t s_rdata_o;
  gpio_t gpio_in_i;
  gpio_t gpio_out_o;
  gpio_t gpio_outenb_o;
  gpio_t gpio_pullupb_o;
  gpio_t gpio_pulldownb_o;
  logic  trap_i;
  irq_t  irq_o;

  int    seed = 23;
  int    cycles = 0;
  // shadow registers
  gpio_t m_out = '0;
  gpio_t m_oeb = '1;
  gpio_t m_pu = '0;
  gpio_t m_pd = '0;
  sel_t  m_trap = '0;
  sel_t  m_irqa = '0;
  sel_t  m_irqb = '0;
  // response hold tracking
  logic  held_b = 1'b0;
  logic  held_r = 1'b0;
  data_t held_data = '0;

  addr_t map_ofs[7] = '{OFS_GPIO_DATA, OFS_GPIO_OEB, OFS_GPIO_PU, OFS_GPIO_PD,
                        OFS_TRAP_DEST, OFS_IRQA_SRC, OFS_IRQB_SRC};
  addr_t gap_ofs[4] = '{8'h10, 8'h38, 8'h48, 8'h74};

  hk_top uut (.*);

  always #4 clk_i = ~clk_i;

  task automatic fail_value(input string name, input data_t exp, input data_t act);
    $display("FAIL time=%0t %s expected=%h actual=%h", $time, name, exp, act);
    $display("** FAIL **");
    $fatal(1, "value mismatch on %s", name);
  endtask

  task automatic fail_msg(input string msg);
    $display("error at time %0t: %s", $time, msg);
    $display("** FAIL **");
    $fatal(1, "%s", msg);
  endtask

  task automatic check_value(input string name, input data_t exp, input data_t act);
    assert (act === exp) else fail_value(name, exp, act);
  endtask

  function automatic gpio_t merge_bytes(input gpio_t old, input data_t d, input strb_t s);
    gpio_t mask;
    mask = {{8{s[1]}}, {8{s[0]}}};
    return (old & ~mask) | (d[15:0] & mask);
  endfunction

  function automatic gpio_t expect_out();
    gpio_t v;
    v = m_out;
    if (m_trap != 2'd0) v[TRAP_PIN_BASE + int'(m_trap)] = trap_i;
    return v;
  endfunction

  // pins 11 to 13 are forced while any trap destination is set
  function automatic gpio_t trap_force(input gpio_t v, input logic level);
    gpio_t r;
    r = v;
    if (m_trap != 2'd0) r[TRAP_PIN_BASE + 1 +: 3] = {3{level}};
    return r;
  endfunction

  function automatic logic src_pick(input sel_t code, input int base);
    if (code == 2'd0) return 1'b0;
    return gpio_in_i[base + int'(code) - 1];
  endfunction

  task automatic model_write(input addr_t addr, input data_t d, input strb_t s);
    case ({addr[7:2], 2'b00})
      OFS_GPIO_DATA: m_out = merge_bytes(m_out, d, s);
      OFS_GPIO_OEB:  m_oeb = merge_bytes(m_oeb, d, s);
      OFS_GPIO_PU:   m_pu = merge_bytes(m_pu, d, s);
      OFS_GPIO_PD:   m_pd = merge_bytes(m_pd, d, s);
      OFS_TRAP_DEST: if (s[0]) m_trap = d[1:0];
      OFS_IRQA_SRC:  if (s[0]) m_irqa = d[1:0];
      OFS_IRQB_SRC:  if (s[0]) m_irqb = d[1:0];
      default: ;
    endcase
  endtask

  function automatic data_t model_read(input addr_t addr);
    case ({addr[7:2], 2'b00})
      OFS_GPIO_DATA: return {expect_out(), gpio_in_i};
      OFS_GPIO_OEB:  return {16'h0, m_oeb};
      OFS_GPIO_PU:   return {16'h0, m_pu};
      OFS_GPIO_PD:   return {16'h0, m_pd};
      OFS_TRAP_DEST: return {30'h0, m_trap};
      OFS_IRQA_SRC:  return {30'h0, m_irqa};
      OFS_IRQB_SRC:  return {30'h0, m_irqb};
      default:       return '0;
    endcase
  endfunction

  // crowd holds a read request behind the write
  task automatic axi_write(input addr_t addr, input data_t data, input strb_t strb,
                           input bit crowd);
    int wait_n;
    int lead_n;
    wait_n = $unsigned($random(seed)) % 4;
    lead_n = $unsigned($random(seed)) % 2;
    @(posedge clk_i);
    s_awvalid_i <= 1'b1;
    s_awaddr_i  <= addr;
    s_wdata_i   <= data;
    s_wstrb_i   <= strb;
    s_arvalid_i <= crowd;
    s_araddr_i  <= OFS_GPIO_OEB;
    // address sometimes leads the data by a cycle
    if (lead_n != 0) begin
      @(posedge clk_i);
    end
    s_wvalid_i  <= 1'b1;
    @(negedge clk_i);
    while (!s_awready_o) @(negedge clk_i);
    @(posedge clk_i);
    s_awvalid_i <= 1'b0;
    s_wvalid_i  <= 1'b0;
    model_write(addr, data, strb);
    @(negedge clk_i);
    check_value("s_bvalid_o", 32'd1, 32'(s_bvalid_o));
    repeat (wait_n + 1) @(posedge clk_i);
    s_bready_i <= 1'b1;
    @(posedge clk_i);
    s_bready_i  <= 1'b0;
    s_arvalid_i <= 1'b0;
  endtask

  // crowd presents a write while the read response waits
  task automatic axi_read(input addr_t addr, input bit crowd, output data_t data);
    int wait_n;
    wait_n = $unsigned($random(seed)) % 4;
    @(posedge clk_i);
    s_arvalid_i <= 1'b1;
    s_araddr_i  <= addr;
    @(negedge clk_i);
    while (!s_arready_o) @(negedge clk_i);
    @(posedge clk_i);
    s_arvalid_i <= 1'b0;
    s_awvalid_i <= crowd;
    s_wvalid_i  <= crowd;
    s_awaddr_i  <= 8'hFC;
    s_wstrb_i   <= '0;
    @(negedge clk_i);
    check_value("s_rvalid_o", 32'd1, 32'(s_rvalid_o));
    data = s_rdata_o;
    repeat (wait_n + 1) @(posedge clk_i);
    s_rready_i <= 1'b1;
    @(posedge clk_i);
    s_rready_i  <= 1'b0;
    s_awvalid_i <= 1'b0;
    s_wvalid_i  <= 1'b0;
  endtask

  task automatic check_pins();
    @(negedge clk_i);
    check_value("gpio_out_o", 32'(expect_out()), 32'(gpio_out_o));
    check_value("gpio_outenb_o", 32'(trap_force(m_oeb, 1'b0)), 32'(gpio_outenb_o));
    check_value("gpio_pullupb_o", 32'(trap_force(m_pu, 1'b1)), 32'(gpio_pullupb_o));
    check_value("gpio_pulldownb_o", 32'(trap_force(m_pd, 1'b1)), 32'(gpio_pulldownb_o));
    check_value("irq_o[2]", 32'(src_pick(m_irqa, IRQA_IN_BASE)), 32'(irq_o[2]));
    check_value("irq_o[3]", 32'(src_pick(m_irqb, IRQB_IN_BASE)), 32'(irq_o[3]));
  endtask

  task automatic wait_irq(input int idx, input int limit);
    int n;
    n = 0;
    @(negedge clk_i);
    while (irq_o[idx] !== 1'b1) begin
      n++;
      if (n > limit) begin
        fail_msg($sformatf("irq_o[%0d] did not rise within %0d cycles", idx, limit));
      end
      @(negedge clk_i);
    end
  endtask

  resp_blocks_accept: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (s_bvalid_o || s_rvalid_o) |-> !(s_awready_o || s_wready_o || s_arready_o))
    else fail_msg("transaction accepted while a response was pending");

  // responses must hold until the master takes them
  always @(negedge clk_i) begin
    if (rst_n_i) begin
      assert (s_awready_o == s_wready_o) else fail_msg("awready and wready differ");
      assert (!(s_arready_o && (s_awvalid_i || s_wvalid_i)))
        else fail_msg("read accepted while a write was presented");
      if (held_b) begin
        assert (s_bvalid_o) else fail_msg("bvalid dropped before bready");
      end
      if (held_r) begin
        assert (s_rvalid_o) else fail_msg("rvalid dropped before rready");
        check_value("s_rdata_o", held_data, s_rdata_o);
      end
    end
    held_b    = s_bvalid_o && !s_bready_i;
    held_r    = s_rvalid_o && !s_rready_i;
    held_data = s_rdata_o;
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("** FAIL **");
      $fatal(1, "timeout, test still running after %0d cycles", cycles);
    end
  end

  initial begin
    int    i;
    addr_t a;
    data_t rd;
    rst_n_i     = 1'b0;
    s_awvalid_i = 1'b0;
    s_awaddr_i  = '0;
    s_wvalid_i  = 1'b0;
    s_wdata_i   = '0;
    s_wstrb_i   = '0;
    s_bready_i  = 1'b0;
    s_arvalid_i = 1'b0;
    s_araddr_i  = '0;
    s_rready_i  = 1'b0;
    gpio_in_i   = '0;
    trap_i      = 1'b0;
    repeat (2) @(posedge clk_i);
    rst_n_i <= 1'b1;

    // reset values
    @(negedge clk_i);
    check_value("{awready,wready,arready,bvalid,rvalid}", 32'd0,
                32'({s_awready_o, s_wready_o, s_arready_o, s_bvalid_o, s_rvalid_o}));
    check_value("irq_o", 32'd0, 32'(irq_o));
    check_pins();

    // random register traffic, random response delays
    @(posedge clk_i);
    gpio_in_i <= gpio_t'($random(seed));
    trap_i    <= 1'b1;
    for (i = 0; i < 40; i++) begin
      a = map_ofs[$unsigned($random(seed)) % 7];
      axi_write(a | addr_t'($unsigned($random(seed)) % 4), data_t'($random(seed)),
                strb_t'($random(seed)), i[0]);
      check_pins();
      axi_read(a, i[1], rd);
      check_value("s_rdata_o", model_read(a), rd);
    end
    for (i = 0; i < 4; i++) begin
      axi_write(gap_ofs[i], data_t'($random(seed)), 4'hF, 1'b0);
      axi_read(gap_ofs[i], 1'b1, rd);
      check_value("s_rdata_o (unmapped)", 32'd0, rd);
    end

    // trap routing over known pin settings
    axi_write(OFS_GPIO_OEB, 32'hFFFF, 4'h3, 1'b0);
    axi_write(OFS_GPIO_PU, 32'h0, 4'h3, 1'b0);
    axi_write(OFS_GPIO_PD, 32'h0, 4'h3, 1'b0);
    for (i = 1; i <= 3; i++) begin
      axi_write(OFS_TRAP_DEST, data_t'(i), 4'h1, 1'b0);
      repeat (2) begin
        @(posedge clk_i);
        trap_i <= ~trap_i;
        check_pins();
      end
    end
    axi_write(OFS_TRAP_DEST, 32'd0, 4'h1, 1'b0);
    check_pins();

    // interrupt source selects
    for (i = 0; i < 4; i++) begin
      axi_write(OFS_IRQA_SRC, data_t'(i), 4'h1, 1'b0);
      axi_write(OFS_IRQB_SRC, data_t'(3 - i), 4'h1, 1'b0);
      repeat (4) begin
        @(posedge clk_i);
        gpio_in_i <= gpio_t'($random(seed));
        check_pins();
      end
    end

    // timer 0 one-shot
    axi_write(OFS_TIM0_DAT, 32'd6, 4'hF, 1'b0);
    axi_write(OFS_TIM0_VAL, 32'd6, 4'hF, 1'b0);
    axi_write(OFS_TIM0_CFG, (1 << CFG_EN) | (1 << CFG_IRQ_EN), 4'h1, 1'b0);
    wait_irq(0, 6 + 5);
    axi_read(OFS_TIM0_CFG, 1'b0, rd);
    check_value("tim0 cfg", (1 << CFG_EXPIRED) | (1 << CFG_IRQ_EN), rd);
    axi_read(OFS_TIM0_VAL, 1'b0, rd);
    check_value("tim0 val", 32'd0, rd);

    // timer 1 continuous, value never above the reload
    axi_write(OFS_TIM1_DAT, 32'd5, 4'hF, 1'b0);
    axi_write(OFS_TIM1_VAL, 32'd5, 4'hF, 1'b0);
    axi_write(OFS_TIM1_CFG, (1 << CFG_EN) | (1 << CFG_CONT) | (1 << CFG_IRQ_EN),
              4'h1, 1'b0);
    for (i = 0; i < 8; i++) begin
      axi_read(OFS_TIM1_VAL, i[0], rd);
      assert (rd <= 32'd5) else fail_value("tim1 val (upper bound)", 32'd5, rd);
    end
    wait_irq(1, 5 + 5);
    axi_read(OFS_TIM1_CFG, 1'b0, rd);
    check_value("tim1 cfg", (1 << CFG_EN) | (1 << CFG_CONT) | (1 << CFG_IRQ_EN) |
                (1 << CFG_EXPIRED), rd);

    // a cfg write clears the sticky expiry
    axi_write(OFS_TIM1_CFG, 32'd0, 4'h1, 1'b0);
    axi_write(OFS_TIM0_CFG, 1 << CFG_IRQ_EN, 4'h1, 1'b0);
    @(negedge clk_i);
    check_value("irq_o[1:0]", 32'd0, 32'(irq_o[1:0]));

    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
rtl/hk_pkg.sv
rtl/axil_slave_fsm.sv
rtl/hk_regs.sv
rtl/hk_timer.sv
rtl/hk_top.sv
verification/tb_hk_top.sv

// File: Makefile
TOP = tb_hk_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -Wno-fatal -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing -Wno-fatal -f all.f --top-module $(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
